// ==== build.f ====
+incdir+include
design/pcie_phy_pkg.sv
design/tx_ctrl_pkg.sv
design/byte_scramble.sv
design/gen1_scramble.sv
design/skp_timer.sv
design/tx_framer_fsm.sv
design/pcie_tx_lane.sv
tb/tb_scramble_ref.sv
tb/tb_pcie_tx_lane.sv

// ==== design/byte_scramble.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_scramble
  import pcie_phy_pkg::*;
(
  input  lfsr_t lfsr_q,
  output lfsr_t lfsr_o
);

  // x^16 + x^5 + x^4 + x^3 + 1 in galois form
  localparam lfsr_t TAPS = 16'h0039;

  lfsr_t step [9];

  assign step[0] = lfsr_q;

  // one step per bit time, eight per byte
  for (genvar b = 0; b < 8; b++) begin : gen_bit_step
    always_comb begin
      if (step[b][15]) begin
        step[b+1] = {step[b][14:0], 1'b0} ^ TAPS;
      end else begin
        step[b+1] = {step[b][14:0], 1'b0};
      end
    end
  end

  // state seen by the next byte lane
  assign lfsr_o = step[8];

endmodule

`default_nettype wire

// ==== design/gen1_scramble.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pcie_tx_defines.svh"

module gen1_scramble
  import pcie_phy_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  pipe_word_t  data_in_i,
  input  logic        data_valid_i,
  input  kmask_t      data_k_in_i,
  input  pipe_width_t pipe_width_i,
  output logic        data_valid_o,
  output pipe_word_t  data_out_o,
  output kmask_t      data_k_out_o
);

  localparam int NLANES = $bits(kmask_t);

  lfsr_t      lfsr_q;
  lfsr_t      lfsr_next;
  lfsr_t      lane_lfsr [NLANES+1];
  logic [2:0] lane_cnt;
  logic       word_has_com;
  pipe_word_t data_d;
  kmask_t     k_d;

  // active lanes for the current width
  always_comb begin
    case (pipe_width_i)
      6'd8:    lane_cnt = 3'd1;
      6'd16:   lane_cnt = 3'd2;
      default: lane_cnt = 3'd4;
    endcase
  end

  // lane 0 scrambles with the held state, each later lane eight bit-times on
  assign lane_lfsr[0] = lfsr_q;

  for (genvar i = 0; i < NLANES; i++) begin : gen_lane_chain
    byte_scramble byte_scramble_i (
      .lfsr_q (lane_lfsr[i]),
      .lfsr_o (lane_lfsr[i+1])
    );
  end

  // state after the last active lane
  always_comb begin
    case (lane_cnt)
      3'd1:    lfsr_next = lane_lfsr[1];
      3'd2:    lfsr_next = lane_lfsr[2];
      default: lfsr_next = lane_lfsr[NLANES];
    endcase
  end

  always_comb begin
    symbol_t sym;
    symbol_t mask;
    word_has_com = 1'b0;
    data_d       = '0;
    k_d          = '0;
    for (int i = 0; i < NLANES; i++) begin
      sym  = data_in_i[i*8 +: 8];
      mask = {<<{lane_lfsr[i][7:0]}};
      if (i < int'(lane_cnt)) begin
        k_d[i] = data_k_in_i[i];
        // K symbols and anything behind a COM go out as they came
        if (data_k_in_i[i] || word_has_com) begin
          data_d[i*8 +: 8] = sym;
        end else begin
          data_d[i*8 +: 8] = sym ^ mask;
        end
        if (data_k_in_i[i] && (sym == COM)) begin
          word_has_com = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_q       <= `LFSR_SEED;
      data_valid_o <= 1'b0;
    end else begin
      data_valid_o <= data_valid_i;
      if (data_valid_i) begin
        // a COM restarts the sequence for the next word
        lfsr_q <= word_has_com ? `LFSR_SEED : lfsr_next;
      end
    end
  end

  // output payload, unused high lanes already zero
  always_ff @(posedge clk_i) begin
    data_out_o   <= data_d;
    data_k_out_o <= k_d;
  end

  // nothing leaves the lane in the first cycle out of reset
  a_no_valid_after_reset : assert property (
    @(posedge clk_i) $fell(rst_i) |=> !data_valid_o
  ) else $error("data_valid_o high in the cycle after reset");

endmodule

`default_nettype wire

// ==== design/pcie_phy_pkg.sv ====
`default_nettype none

`include "pcie_tx_defines.svh"

package pcie_phy_pkg;

  // one 8b symbol before 8b/10b encoding
  typedef logic [7:0] symbol_t;

  // full PIPE data word, lane 0 in the low byte
  typedef logic [`PIPE_W_MAX-1:0] pipe_word_t;

  // one K flag per byte lane
  typedef logic [`PIPE_W_MAX/8-1:0] kmask_t;

  // gen1 scrambler state
  typedef logic [15:0] lfsr_t;

  // pipe width in bits, 8, 16 or 32
  typedef logic [5:0] pipe_width_t;

  // special symbols
  localparam symbol_t COM  = 8'hBC;  // K28.5
  localparam symbol_t SKP  = 8'h1C;  // K28.0
  localparam symbol_t PAD_ = 8'hF7;  // K23.7

endpackage

`default_nettype wire

// ==== design/pcie_tx_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcie_tx_lane
  import pcie_phy_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  pipe_width_t pipe_width_i,
  input  logic        req_i,
  input  pipe_word_t  host_data_i,
  input  kmask_t      host_k_i,
  output logic        ack_o,
  output logic        data_valid_o,
  output pipe_word_t  data_out_o,
  output kmask_t      data_k_out_o
);

  logic       word_valid;
  pipe_word_t word_data;
  kmask_t     word_k;
  logic       word_issued;
  logic       skp_start;
  logic       skp_due;

  // host handshake and ordered set insertion
  tx_framer_fsm tx_framer_fsm_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_i         (req_i),
    .host_data_i   (host_data_i),
    .host_k_i      (host_k_i),
    .pipe_width_i  (pipe_width_i),
    .skp_due_i     (skp_due),
    .ack_o         (ack_o),
    .word_valid_o  (word_valid),
    .word_data_o   (word_data),
    .word_k_o      (word_k),
    .word_issued_o (word_issued),
    .skp_start_o   (skp_start)
  );

  skp_timer skp_timer_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .word_issued_i (word_issued),
    .skp_start_i   (skp_start),
    .skp_due_o     (skp_due)
  );

  // one register stage to the PHY
  gen1_scramble gen1_scramble_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .data_in_i    (word_data),
    .data_valid_i (word_valid),
    .data_k_in_i  (word_k),
    .pipe_width_i (pipe_width_i),
    .data_valid_o (data_valid_o),
    .data_out_o   (data_out_o),
    .data_k_out_o (data_k_out_o)
  );

endmodule

`default_nettype wire

// ==== design/skp_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pcie_tx_defines.svh"

module skp_timer
  import tx_ctrl_pkg::*;
(
  input  logic clk_i,
  input  logic rst_i,
  input  logic word_issued_i,
  input  logic skp_start_i,
  output logic skp_due_o
);

  localparam skp_count_t INTERVAL = skp_count_t'(`SKP_INTERVAL);

  skp_count_t count_q;

  // count host words since the last ordered set
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (skp_start_i) begin
      count_q <= '0;
    end else if (word_issued_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  // due from the edge that reaches the interval
  assign skp_due_o = (count_q == INTERVAL);

  // the framer never issues a host word while a SKP is pending
  a_count_in_range : assert property (
    @(posedge clk_i) disable iff (rst_i)
    count_q <= INTERVAL
  ) else $error("SKP word count passed the interval");

endmodule

`default_nettype wire

// ==== design/tx_ctrl_pkg.sv ====
`default_nettype none

package tx_ctrl_pkg;

  // framer states
  //   IDLE      waiting for a request or a due SKP
  //   DATA_ACK  host word issued, ack high
  //   SKP_OS    issuing the ordered set
  //   ACK_DROP  waiting for req to fall
  typedef enum logic [1:0] {
    IDLE,
    DATA_ACK,
    SKP_OS,
    ACK_DROP
  } framer_state_t;

  // issued word count, wide enough for the SKP interval
  typedef logic [4:0] skp_count_t;

endpackage

`default_nettype wire

// ==== design/tx_framer_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_framer_fsm
  import pcie_phy_pkg::*;
  import tx_ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        req_i,
  input  pipe_word_t  host_data_i,
  input  kmask_t      host_k_i,
  input  pipe_width_t pipe_width_i,
  input  logic        skp_due_i,
  output logic        ack_o,
  output logic        word_valid_o,
  output pipe_word_t  word_data_o,
  output kmask_t      word_k_o,
  output logic        word_issued_o,
  output logic        skp_start_o
);

  localparam int NLANES = $bits(kmask_t);

  framer_state_t state_q;
  logic [2:0]    lane_cnt;
  logic [2:0]    sym_idx_q;
  logic [2:0]    sym_idx_next;
  logic          host_accept;
  pipe_word_t    skp_data;
  kmask_t        skp_k;

  always_comb begin
    case (pipe_width_i)
      6'd8:    lane_cnt = 3'd1;
      6'd16:   lane_cnt = 3'd2;
      default: lane_cnt = 3'd4;
    endcase
  end

  // a due SKP wins over a waiting request
  assign host_accept   = (state_q == IDLE) && req_i && !skp_due_i;
  assign skp_start_o   = (state_q == IDLE) && skp_due_i;
  assign word_issued_o = host_accept;

  assign sym_idx_next = sym_idx_q + lane_cnt;

  // next slice of COM SKP SKP SKP
  always_comb begin
    skp_data = '0;
    skp_k    = '0;
    for (int i = 0; i < NLANES; i++) begin
      if (i < int'(lane_cnt)) begin
        skp_data[i*8 +: 8] = ((int'(sym_idx_q) + i) == 0) ? COM : SKP;
        skp_k[i]           = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= IDLE;
      ack_o        <= 1'b0;
      word_valid_o <= 1'b0;
      sym_idx_q    <= '0;
    end else begin
      word_valid_o <= 1'b0;
      case (state_q)
        IDLE: begin
          if (skp_due_i) begin
            sym_idx_q <= '0;
            state_q   <= SKP_OS;
          end else if (req_i) begin
            ack_o        <= 1'b1;
            word_valid_o <= 1'b1;
            state_q      <= DATA_ACK;
          end
        end
        DATA_ACK: begin
          // host may already have dropped req
          if (!req_i) begin
            ack_o   <= 1'b0;
            state_q <= IDLE;
          end else begin
            state_q <= ACK_DROP;
          end
        end
        ACK_DROP: begin
          if (!req_i) begin
            ack_o   <= 1'b0;
            state_q <= IDLE;
          end
        end
        SKP_OS: begin
          word_valid_o <= 1'b1;
          sym_idx_q    <= sym_idx_next;
          if (sym_idx_next >= 3'd4) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // word payload to the scrambler
  always_ff @(posedge clk_i) begin
    if (host_accept) begin
      word_data_o <= host_data_i;
      word_k_o    <= host_k_i;
    end else if (state_q == SKP_OS) begin
      word_data_o <= skp_data;
      word_k_o    <= skp_k;
    end
  end

  a_ack_needs_req : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !req_i |=> !$rose(ack_o)
  ) else $error("ack_o rose without a request");

  a_no_word_in_ack_drop : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (state_q == ACK_DROP) |-> !word_valid_o
  ) else $error("word issued while waiting for req to fall");

endmodule

`default_nettype wire

// ==== include/pcie_tx_defines.svh ====
`ifndef PCIE_TX_DEFINES_SVH
`define PCIE_TX_DEFINES_SVH

// issued host words between two SKP ordered sets
// kept short so a simulation reaches several of them
`define SKP_INTERVAL 16

// scrambler state after reset and after every COM
`define LFSR_SEED 16'hFFFF

// widest PIPE word in bits, four byte lanes
`define PIPE_W_MAX 32

`endif

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_pcie_tx_lane -o sim_tb && ./obj_dir/sim_tb > sim.log 2>&1
grep -q "TESTS PASSED" sim.log && echo "run_sim: pass" || { echo "run_sim: fail"; exit 1; }

// ==== tb/tb_pcie_tx_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pcie_tx_defines.svh"

module tb_pcie_tx_lane
  import pcie_phy_pkg::*;
  import tb_scramble_ref::*;
();

  localparam int TOTAL_WORDS = 168;
  localparam int CLK_PERIOD  = 100;
  localparam int LIMIT_CYCLES = TOTAL_WORDS * 20 + 200;

  logic        clk;
  logic        rst;
  pipe_width_t pipe_width;
  logic        req;
  pipe_word_t  host_data;
  kmask_t      host_k;
  logic        ack;
  logic        data_valid;
  pipe_word_t  data_out;
  kmask_t      data_k_out;

  pipe_word_t exp_data_q [$];
  kmask_t     exp_k_q [$];
  lfsr_t      model_lfsr;
  int         issued_cnt;
  logic       seen_req;
  logic       chk_valid;
  logic       extra_word;
  pipe_word_t got_data;
  pipe_word_t exp_data;
  kmask_t     got_k;
  kmask_t     exp_k;

  pcie_tx_lane pcie_tx_lane_i (
    .clk_i        (clk),
    .rst_i        (rst),
    .pipe_width_i (pipe_width),
    .req_i        (req),
    .host_data_i  (host_data),
    .host_k_i     (host_k),
    .ack_o        (ack),
    .data_valid_o (data_valid),
    .data_out_o   (data_out),
    .data_k_out_o (data_k_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("TESTS FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic report_mismatch(input string sig, input pipe_word_t got, input pipe_word_t exp);
    $display("Mismatch at %0t: %s got %h expected %h", $time, sig, got, exp);
    abort_run("output compare failed");
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t: %s", $time, what);
    abort_run(what);
  endtask

  // push one expected PHY word and move the model LFSR on
  task automatic expect_word(input pipe_word_t d, input kmask_t k, input int lanes);
    exp_data_q.push_back(scramble_word(d, k, lanes, model_lfsr));
    exp_k_q.push_back(active_k(k, lanes));
    model_lfsr = next_state(d, k, lanes, model_lfsr);
  endtask

  // COM then SKP symbols, sliced into words of the current width
  task automatic expect_skp_set(input int lanes);
    pipe_word_t d;
    kmask_t     k;
    for (int j = 0; j < 4 / lanes; j++) begin
      d = '0;
      k = '0;
      for (int i = 0; i < lanes; i++) begin
        d[8*i +: 8] = ((j * lanes + i) == 0) ? COM : SKP;
        k[i]        = 1'b1;
      end
      expect_word(d, k, lanes);
    end
  endtask

  // four-phase handshake for one host word
  task automatic send_word(input pipe_word_t d, input kmask_t k);
    int lanes;
    lanes = lane_count(pipe_width);
    expect_word(d, k, lanes);
    issued_cnt++;
    if (issued_cnt == `SKP_INTERVAL) begin
      expect_skp_set(lanes);
      issued_cnt = 0;
    end
    host_data = d;
    host_k    = k;
    req       = 1'b1;
    seen_req  = 1'b1;
    do @(negedge clk); while (!ack);
    req = 1'b0;
    do @(negedge clk); while (ack);
  endtask

  task automatic send_mixed_word();
    pipe_word_t d;
    kmask_t     k;
    int         lane;
    d = $urandom();
    k = kmask_t'($urandom());
    // about one word in four carries a COM
    if ($urandom_range(3) == 0) begin
      lane            = $urandom_range(lane_count(pipe_width) - 1);
      k[lane]         = 1'b1;
      d[8*lane +: 8]  = COM;
    end
    send_word(d, k);
  endtask

  task automatic run_phase(input pipe_width_t w, input int n, input logic mixed);
    // width only changes with the lane drained
    while (exp_data_q.size() != 0) @(negedge clk);
    pipe_width = w;
    @(negedge clk);
    repeat (n) begin
      if (mixed) begin
        send_mixed_word();
      end else begin
        send_word($urandom(), '0);
      end
    end
  endtask

  // capture each output word next to its expected value
  always @(negedge clk) begin
    chk_valid = 1'b0;
    if (!rst && data_valid) begin
      if (exp_data_q.size() == 0) begin
        extra_word = 1'b1;
      end else begin
        got_data  = data_out;
        got_k     = data_k_out;
        exp_data  = exp_data_q.pop_front();
        exp_k     = exp_k_q.pop_front();
        chk_valid = 1'b1;
      end
    end
  end

  a_data : assert property (@(posedge clk) disable iff (rst)
    chk_valid |-> (got_data == exp_data)
  ) else report_mismatch("data_out_o", got_data, exp_data);

  a_k_flags : assert property (@(posedge clk) disable iff (rst)
    chk_valid |-> (got_k == exp_k)
  ) else report_mismatch("data_k_out_o", pipe_word_t'(got_k), pipe_word_t'(exp_k));

  a_no_extra : assert property (@(posedge clk) disable iff (rst)
    !extra_word
  ) else report_failure("output word arrived with no word expected");

  a_quiet_start : assert property (@(posedge clk) disable iff (rst)
    !seen_req |-> (!ack && !data_valid)
  ) else report_failure("ack_o or data_valid_o went high before the first request");

  a_ack_rise : assert property (@(posedge clk) disable iff (rst)
    $rose(ack) |-> $past(req)
  ) else report_failure("ack_o rose while req_i was low");

  a_ack_fall : assert property (@(posedge clk) disable iff (rst)
    $fell(ack) |-> !$past(req)
  ) else report_failure("ack_o fell while req_i was still high");

  a_valid_after_ack : assert property (@(posedge clk) disable iff (rst)
    $rose(ack) |=> data_valid
  ) else report_failure("data_valid_o missing one cycle after ack_o rose");

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    report_failure("watchdog expired before all words came out");
  end

  initial begin
    void'($urandom(32'h69c0_88ed));
    rst        = 1'b1;
    req        = 1'b0;
    host_data  = '0;
    host_k     = '0;
    pipe_width = 6'd32;
    model_lfsr = `LFSR_SEED;
    issued_cnt = 0;
    seen_req   = 1'b0;
    chk_valid  = 1'b0;
    extra_word = 1'b0;
    got_data   = '0;
    exp_data   = '0;
    got_k      = '0;
    exp_k      = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // lane must stay quiet here
    repeat (6) @(negedge clk);

    run_phase(6'd32, 40, 1'b0);
    run_phase(6'd16, 40, 1'b0);
    run_phase(6'd8, 40, 1'b0);
    run_phase(6'd32, 24, 1'b1);
    run_phase(6'd16, 24, 1'b1);

    while (exp_data_q.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/tb_scramble_ref.sv ====
`default_nettype none

`include "pcie_tx_defines.svh"

package tb_scramble_ref;

  import pcie_phy_pkg::*;

  // gen1 polynomial x^16 + x^5 + x^4 + x^3 + 1, eight bit times
  function automatic lfsr_t advance_byte(input lfsr_t s);
    lfsr_t r;
    logic  fb;
    r = s;
    for (int b = 0; b < 8; b++) begin
      fb   = r[15];
      r    = r << 1;
      r[0] = fb;
      r[3] = r[3] ^ fb;
      r[4] = r[4] ^ fb;
      r[5] = r[5] ^ fb;
    end
    return r;
  endfunction

  // scrambling bits leave lsb first, so the byte mask is mirrored
  function automatic symbol_t mirror_byte(input symbol_t b);
    symbol_t m;
    for (int i = 0; i < 8; i++) begin
      m[i] = b[7-i];
    end
    return m;
  endfunction

  function automatic int lane_count(input pipe_width_t w);
    return int'(w) / 8;
  endfunction

  function automatic kmask_t active_k(input kmask_t k, input int lanes);
    kmask_t m;
    m = '0;
    for (int i = 0; i < lanes; i++) begin
      m[i] = k[i];
    end
    return m;
  endfunction

  // expected PHY word for one issued word and the LFSR it starts from
  function automatic pipe_word_t scramble_word(input pipe_word_t d, input kmask_t k,
                                               input int lanes, input lfsr_t s);
    pipe_word_t o;
    lfsr_t      st;
    logic       after_com;
    symbol_t    sym;
    o         = '0;
    st        = s;
    after_com = 1'b0;
    for (int i = 0; i < lanes; i++) begin
      sym = d[8*i +: 8];
      if (k[i] || after_com) begin
        o[8*i +: 8] = sym;
      end else begin
        o[8*i +: 8] = sym ^ mirror_byte(st[7:0]);
      end
      if (k[i] && (sym == COM)) begin
        after_com = 1'b1;
      end
      st = advance_byte(st);
    end
    return o;
  endfunction

  // LFSR seen by the following word
  function automatic lfsr_t next_state(input pipe_word_t d, input kmask_t k,
                                       input int lanes, input lfsr_t s);
    lfsr_t st;
    logic  com_seen;
    st       = s;
    com_seen = 1'b0;
    for (int i = 0; i < lanes; i++) begin
      if (k[i] && (d[8*i +: 8] == COM)) begin
        com_seen = 1'b1;
      end
      st = advance_byte(st);
    end
    return com_seen ? `LFSR_SEED : st;
  endfunction

endpackage

`default_nettype wire
